//--- dv/ps2_device_model.sv
////////////////////////////////////////////////////////////////////////////
// Behavioral device; lines change 1 ns after the rising system clock
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_device_model #(
	parameter int HALF_CYCLES = 15
)
(
	input  logic       clk,
	input  logic       ps2_clk_pull,
	input  logic       ps2_dat_pull,
	input  logic       frame_req,
	input  logic       silent,
	input  logic [7:0] frame_byte,
	input  logic [7:0] reply_byte,
	output logic       ps2_clk_in,
	output logic       ps2_dat_in,
	output logic [7:0] cmd_byte,
	output logic       cmd_parity,
	output logic       cmd_stop,
	output logic [7:0] cmd_count,
	output logic       fault
);

	localparam int LIMIT = 20000;

	logic dev_clk;
	logic dev_dat;

	// Open-drain lines, low wins
	assign ps2_clk_in = dev_clk & ~ps2_clk_pull;
	assign ps2_dat_in = dev_dat & ~ps2_dat_pull;

	task automatic idle_for(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Start, 8 data LSB first, odd parity, stop; data moves while clock high
	task automatic send_frame(input logic [7:0] b);
		logic [11:0] bits;
		// Top bit is the idle level after the stop bit
		bits = {2'b11, ~(^b), b, 1'b0};
		dev_dat = bits[0];
		idle_for(HALF_CYCLES);
		for (int i = 0; i < 11; i++)
		begin
			dev_clk = 1'b0;
			idle_for(HALF_CYCLES);
			dev_clk = 1'b1;
			// Bit held past the rise, where the host samples it
			idle_for(HALF_CYCLES / 3);
			dev_dat = bits[i+1];
			idle_for(HALF_CYCLES - HALF_CYCLES / 3);
		end
	endtask

	task automatic take_command();
		int n;
		logic [9:0] bits;
		n = 0;
		while (ps2_clk_pull && n < LIMIT)
		begin
			idle_for(1);
			n++;
		end
		if (n >= LIMIT)
		begin
			fault = 1'b1;
			$display("Device model: host never released the clock line");
			return;
		end
		// Silent device just waits out the host's start timeout
		if (silent)
		begin
			n = 0;
			while (ps2_dat_pull && n < LIMIT)
			begin
				idle_for(1);
				n++;
			end
			if (n >= LIMIT)
			begin
				fault = 1'b1;
				$display("Device model: host never released the data line");
			end
			return;
		end
		idle_for(10);
		// Data, parity, stop; read at the end of each low phase
		for (int i = 0; i < 10; i++)
		begin
			dev_clk = 1'b0;
			idle_for(HALF_CYCLES);
			bits[i] = ps2_dat_in;
			dev_clk = 1'b1;
			idle_for(HALF_CYCLES);
		end
		// Acknowledge clock with data held low
		dev_dat = 1'b0;
		dev_clk = 1'b0;
		idle_for(HALF_CYCLES);
		dev_clk = 1'b1;
		idle_for(HALF_CYCLES);
		dev_dat = 1'b1;
		cmd_byte   = bits[7:0];
		cmd_parity = bits[8];
		cmd_stop   = bits[9];
		cmd_count  = cmd_count + 8'd1;
		// Reply byte, as a real device acks a command
		idle_for(40);
		send_frame(reply_byte);
	endtask

	initial
	begin
		int n;
		dev_clk    = 1'b1;
		dev_dat    = 1'b1;
		cmd_byte   = 8'h00;
		cmd_parity = 1'b0;
		cmd_stop   = 1'b0;
		cmd_count  = 8'd0;
		fault      = 1'b0;
		forever
		begin
			idle_for(1);
			if (frame_req)
			begin
				send_frame(frame_byte);
				n = 0;
				while (frame_req && n < LIMIT)
				begin
					idle_for(1);
					n++;
				end
				if (n >= LIMIT)
				begin
					fault = 1'b1;
					$display("Device model: frame request never dropped");
				end
			end
			else if (ps2_clk_pull)
				take_command();
		end
	end

endmodule

//--- dv/ps2_host_chk.sv
////////////////////////////////////////////////////////////////////////////
// Output protocol properties, bound onto every ps2_host instance
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_host_chk (
	input logic clk,
	input logic reset,
	input logic received_data_en,
	input logic command_was_sent,
	input logic error_timed_out,
	input logic ps2_clk_pull,
	input logic ps2_dat_pull
);

	// Byte strobe is a single cycle
	strobe_single: assert property (@(posedge clk) disable iff (reset)
		received_data_en |=> !received_data_en)
		else $error("received_data_en held high for two cycles");

	// Done and timeout exclude each other
	status_mutex: assert property (@(posedge clk) disable iff (reset)
		!(command_was_sent && error_timed_out))
		else $error("command_was_sent and error_timed_out high together");

	// Lines released under reset
	pulls_in_reset: assert property (@(posedge clk)
		reset |=> (!ps2_clk_pull && !ps2_dat_pull))
		else $error("line pull active during reset");

endmodule

bind ps2_host ps2_host_chk chk_inst (
	.clk              (clk),
	.reset            (reset),
	.received_data_en (received_data_en),
	.command_was_sent (command_was_sent),
	.error_timed_out  (error_timed_out),
	.ps2_clk_pull     (ps2_clk_pull),
	.ps2_dat_pull     (ps2_dat_pull)
);

//--- dv/ps2_host_tb.sv
////////////////////////////////////////////////////////////////////////////
// Short timeouts for simulation; inputs change 2 ns after the rising edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_host_tb
	import ps2_frame_pkg::*;
();

	localparam int REQ_CYC = 40;
	localparam int START_CYC = 2000;
	localparam int BIT_CYC = 1500;
	localparam int TIMEOUT = 20000;
	localparam int NROWS = 8;

	// Row kinds
	localparam logic [1:0] KIND_DEV = 2'd0;
	localparam logic [1:0] KIND_CMD = 2'd1;
	localparam logic [1:0] KIND_SILENT = 2'd2;
	// Expected status
	localparam logic [1:0] STAT_NONE = 2'd0;
	localparam logic [1:0] STAT_SENT = 2'd1;
	localparam logic [1:0] STAT_TIMEOUT = 2'd2;

	logic clk = 1'b0;
	logic reset;
	ps2_byte_t command;
	logic send_command;
	logic command_was_sent;
	logic error_timed_out;
	ps2_byte_t received_data;
	logic received_data_en;
	logic ps2_clk_in;
	logic ps2_dat_in;
	logic ps2_clk_pull;
	logic ps2_dat_pull;

	// Device control and scoreboard links
	logic frame_req;
	logic silent;
	logic [7:0] frame_byte;
	logic [7:0] reply_byte;
	logic [7:0] cmd_byte;
	logic cmd_parity;
	logic cmd_stop;
	logic [7:0] cmd_count;
	logic model_fault;
	logic [1:0] row_kind;
	ps2_byte_t row_byte;
	ps2_byte_t row_reply;
	logic [1:0] row_status;
	logic row_done;
	logic report;
	int wait_timeouts;
	int error_count;

	// Stimulus table
	logic [1:0] tbl_kind [NROWS];
	logic [7:0] tbl_byte [NROWS];
	logic [7:0] tbl_reply [NROWS];
	logic [1:0] tbl_status [NROWS];

	always #20 clk = ~clk;

	ps2_host #(
		.REQUEST_CYCLES       (REQ_CYC),
		.START_TIMEOUT_CYCLES (START_CYC),
		.BIT_TIMEOUT_CYCLES   (BIT_CYC)
	) ps2_host_inst (
		.clk              (clk),
		.reset            (reset),
		.command          (command),
		.send_command     (send_command),
		.command_was_sent (command_was_sent),
		.error_timed_out  (error_timed_out),
		.received_data    (received_data),
		.received_data_en (received_data_en),
		.ps2_clk_in       (ps2_clk_in),
		.ps2_dat_in       (ps2_dat_in),
		.ps2_clk_pull     (ps2_clk_pull),
		.ps2_dat_pull     (ps2_dat_pull)
	);

	ps2_device_model device_inst (
		.clk          (clk),
		.ps2_clk_pull (ps2_clk_pull),
		.ps2_dat_pull (ps2_dat_pull),
		.frame_req    (frame_req),
		.silent       (silent),
		.frame_byte   (frame_byte),
		.reply_byte   (reply_byte),
		.ps2_clk_in   (ps2_clk_in),
		.ps2_dat_in   (ps2_dat_in),
		.cmd_byte     (cmd_byte),
		.cmd_parity   (cmd_parity),
		.cmd_stop     (cmd_stop),
		.cmd_count    (cmd_count),
		.fault        (model_fault)
	);

	ps2_scoreboard #(
		.REQUEST_CYCLES (REQ_CYC)
	) scoreboard_inst (
		.clk              (clk),
		.reset            (reset),
		.received_data    (received_data),
		.received_data_en (received_data_en),
		.command_was_sent (command_was_sent),
		.error_timed_out  (error_timed_out),
		.ps2_clk_pull     (ps2_clk_pull),
		.ps2_dat_pull     (ps2_dat_pull),
		.send_command     (send_command),
		.row_kind         (row_kind),
		.row_byte         (row_byte),
		.row_reply        (row_reply),
		.row_status       (row_status),
		.row_done         (row_done),
		.cmd_byte         (cmd_byte),
		.cmd_parity       (cmd_parity),
		.cmd_stop         (cmd_stop),
		.cmd_count        (cmd_count),
		.model_fault      (model_fault),
		.report           (report),
		.wait_timeouts    (wait_timeouts),
		.error_count      (error_count)
	);

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic count_timeout(input string what);
		$display("Timeout: no %s within %0d cycles", what, TIMEOUT);
		wait_timeouts++;
	endtask

	task automatic wait_strobe(input string what);
		int n;
		n = 0;
		while (!received_data_en && n < TIMEOUT)
		begin
			wait_cycles(1);
			n++;
		end
		if (n >= TIMEOUT)
			count_timeout(what);
	endtask

	task automatic wait_status();
		int n;
		n = 0;
		while (!command_was_sent && !error_timed_out && n < TIMEOUT)
		begin
			wait_cycles(1);
			n++;
		end
		if (n >= TIMEOUT)
			count_timeout("command status");
	endtask

	task automatic wait_status_clear();
		int n;
		n = 0;
		while ((command_was_sent || error_timed_out) && n < TIMEOUT)
		begin
			wait_cycles(1);
			n++;
		end
		if (n >= TIMEOUT)
			count_timeout("status clear after send_command dropped");
	endtask

	// Kind, byte, reply byte and expected status of one row
	task automatic set_row(input int i, input logic [1:0] kind, input logic [7:0] data,
		input logic [7:0] reply, input logic [1:0] status);
		tbl_kind[i]   = kind;
		tbl_byte[i]   = data;
		tbl_reply[i]  = reply;
		tbl_status[i] = status;
	endtask

	// Fixed rows first, then random payloads
	task automatic build_table();
		set_row(0, KIND_DEV,    8'hA5,          8'hFA, STAT_NONE);
		set_row(1, KIND_CMD,    8'hF4,          8'hFA, STAT_SENT);
		set_row(2, KIND_SILENT, 8'hFF,          8'hFA, STAT_TIMEOUT);
		set_row(3, KIND_DEV,    8'($urandom()), 8'hFA, STAT_NONE);
		set_row(4, KIND_CMD,    8'($urandom()), 8'hFA, STAT_SENT);
		set_row(5, KIND_DEV,    8'($urandom()), 8'hFA, STAT_NONE);
		set_row(6, KIND_CMD,    8'($urandom()), 8'hFA, STAT_SENT);
		set_row(7, KIND_DEV,    8'h00,          8'hFA, STAT_NONE);
	endtask

	task automatic apply_row(input int i);
		row_kind   = tbl_kind[i];
		row_byte   = tbl_byte[i];
		row_reply  = tbl_reply[i];
		row_status = tbl_status[i];
		if (tbl_kind[i] == KIND_DEV)
		begin
			frame_byte = tbl_byte[i];
			frame_req  = 1'b1;
			wait_strobe("device byte strobe");
			frame_req = 1'b0;
		end
		else
		begin
			silent       = (tbl_kind[i] == KIND_SILENT);
			reply_byte   = tbl_reply[i];
			command      = tbl_byte[i];
			send_command = 1'b1;
			wait_status();
			// Reply must land while send_command is still held
			if (command_was_sent && tbl_kind[i] == KIND_CMD)
				wait_strobe("reply byte strobe");
			send_command = 1'b0;
			wait_status_clear();
			silent = 1'b0;
		end
		wait_cycles(40);
		row_done = 1'b1;
		wait_cycles(1);
		row_done = 1'b0;
	endtask

	initial
	begin
		reset         = 1'b1;
		command       = 8'h00;
		send_command  = 1'b0;
		frame_req     = 1'b0;
		silent        = 1'b0;
		frame_byte    = 8'h00;
		reply_byte    = 8'hFA;
		row_kind      = KIND_DEV;
		row_byte      = 8'h00;
		row_reply     = 8'h00;
		row_status    = STAT_NONE;
		row_done      = 1'b0;
		report        = 1'b0;
		wait_timeouts = 0;
		void'($urandom(16309));
		build_table();
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		wait_cycles(20);
		// A stuck row stops the remaining ones
		for (int i = 0; i < NROWS && wait_timeouts == 0; i++)
			apply_row(i);
		report = 1'b1;
		wait_cycles(2);
		if (error_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- dv/ps2_scoreboard.sv
////////////////////////////////////////////////////////////////////////////
// Compares per row on row_done; counts reset when each row is closed
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_scoreboard
	import ps2_frame_pkg::*;
#(
	parameter int REQUEST_CYCLES = 40
)
(
	input  logic       clk,
	input  logic       reset,
	input  ps2_byte_t  received_data,
	input  logic       received_data_en,
	input  logic       command_was_sent,
	input  logic       error_timed_out,
	input  logic       ps2_clk_pull,
	input  logic       ps2_dat_pull,
	input  logic       send_command,
	input  logic [1:0] row_kind,
	input  ps2_byte_t  row_byte,
	input  ps2_byte_t  row_reply,
	input  logic [1:0] row_status,
	input  logic       row_done,
	input  logic [7:0] cmd_byte,
	input  logic       cmd_parity,
	input  logic       cmd_stop,
	input  logic [7:0] cmd_count,
	input  logic       model_fault,
	input  logic       report,
	input  int         wait_timeouts,
	output int         error_count
);

	// Row kinds and status codes as the testbench encodes them
	localparam logic [1:0] KIND_DEV = 2'd0;
	localparam logic [1:0] KIND_CMD = 2'd1;
	localparam logic [1:0] KIND_SILENT = 2'd2;

	int value_errs = 0;
	int other_errs = 0;
	int rows_seen = 0;
	int strobes = 0;
	int pull_len = 0;
	logic sent_seen = 1'b0;
	logic timeout_seen = 1'b0;
	logic reset_was_high = 1'b0;
	logic send_was_low = 1'b0;
	logic reported = 1'b0;
	logic [7:0] cmd_base = 8'd0;

	assign error_count = value_errs + other_errs + wait_timeouts;

	task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			value_errs++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Parity bit that leaves an odd count of ones over all nine bits
	function automatic logic expected_parity(input ps2_byte_t b);
		int ones;
		ones = 0;
		for (int k = 0; k < 8; k++)
			if (b[k])
				ones++;
		return (ones % 2 == 0) ? 1'b1 : 1'b0;
	endfunction

	task automatic close_row();
		logic [7:0] got;
		got = cmd_count - cmd_base;
		check_hex("received_data_en count", (row_kind == KIND_SILENT) ? 32'd0 : 32'd1,
			32'(strobes));
		check_hex("command_was_sent", 32'(row_status == 2'd1), 32'(sent_seen));
		check_hex("error_timed_out", 32'(row_status == 2'd2), 32'(timeout_seen));
		check_hex("device command count", 32'(row_kind == KIND_CMD), 32'(got));
		if (row_kind == KIND_CMD)
		begin
			check_hex("device command byte", 32'(row_byte), 32'(cmd_byte));
			check_hex("device command parity", 32'(expected_parity(row_byte)),
				32'(cmd_parity));
			check_hex("device command stop", 32'd1, 32'(cmd_stop));
		end
		if (model_fault)
		begin
			other_errs++;
			$display("Device model reported a protocol fault in row %0d", rows_seen);
		end
		rows_seen++;
		strobes = 0;
		sent_seen = 1'b0;
		timeout_seen = 1'b0;
		cmd_base = cmd_count;
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			// Idle outputs once reset has taken hold
			if (reset_was_high)
			begin
				check_hex("ps2_clk_pull", 32'd0, 32'(ps2_clk_pull));
				check_hex("ps2_dat_pull", 32'd0, 32'(ps2_dat_pull));
				check_hex("command_was_sent", 32'd0, 32'(command_was_sent));
				check_hex("error_timed_out", 32'd0, 32'(error_timed_out));
				check_hex("received_data_en", 32'd0, 32'(received_data_en));
			end
		end
		else
		begin
			if (received_data_en)
			begin
				strobes++;
				// Command rows only see the device reply
				if (row_kind == KIND_DEV)
					check_hex("received_data", 32'(row_byte), 32'(received_data));
				else
					check_hex("received_data", 32'(row_reply), 32'(received_data));
			end
			if (command_was_sent)
				sent_seen = 1'b1;
			if (error_timed_out)
				timeout_seen = 1'b1;
			// Status must clear one cycle after send_command is seen low
			if (send_was_low && !send_command && (command_was_sent || error_timed_out))
			begin
				other_errs++;
				$display("Status output still high after send_command dropped");
			end
			// Request length, measured on every clock pull
			if (ps2_clk_pull)
				pull_len++;
			else if (pull_len != 0)
			begin
				check_hex("ps2_clk_pull cycles", 32'(REQUEST_CYCLES), 32'(pull_len));
				pull_len = 0;
			end
			if (row_done)
				close_row();
			if (report && !reported)
			begin
				reported = 1'b1;
				$display("Scoreboard: %0d rows, %0d value errors, %0d other errors, %0d timeouts",
					rows_seen, value_errs, other_errs, wait_timeouts);
			end
		end
		reset_was_high = reset;
		send_was_low = !send_command;
	end

endmodule

//--- logic/ps2_frame_pkg.sv
////////////////////////////////////////////////////////////////////////////
// PS/2 frame layout: 8 data bits LSB first plus odd parity
////////////////////////////////////////////////////////////////////////////
package ps2_frame_pkg;

	// Data bits in one frame
	localparam int DATA_BITS = 8;

	// Byte exchanged with the user side
	typedef logic [DATA_BITS-1:0] ps2_byte_t;

	// Counts data bits and the parity slot
	typedef logic [3:0] bit_index_t;

	// Parity bit that makes the nine-bit count of ones odd
	function automatic logic ps2_odd_parity(input ps2_byte_t data);
		logic ones_odd;
		ones_odd = ^data;
		// Already odd means parity must be 0
		return ~ones_odd;
	endfunction

endpackage

//--- logic/ps2_host.sv
////////////////////////////////////////////////////////////////////////////
// Pull outputs high mean drive the line low; lines need external pull-ups
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_host
	import ps2_frame_pkg::*;
	import ps2_timing_pkg::*;
#(
	parameter int REQUEST_CYCLES       = DEF_REQUEST_CYCLES,
	parameter int START_TIMEOUT_CYCLES = DEF_START_TIMEOUT_CYCLES,
	parameter int BIT_TIMEOUT_CYCLES   = DEF_BIT_TIMEOUT_CYCLES
)
(
	input  logic      clk,
	input  logic      reset,
	// User side
	input  ps2_byte_t command,
	input  logic      send_command,
	output logic      command_was_sent,
	output logic      error_timed_out,
	output ps2_byte_t received_data,
	output logic      received_data_en,
	// Line side
	input  logic      ps2_clk_in,
	input  logic      ps2_dat_in,
	output logic      ps2_clk_pull,
	output logic      ps2_dat_pull
);

	// Sampled line state
	logic line_data;
	logic clk_rise;
	logic clk_fall;

	// Arbiter controls
	logic rx_start;
	logic rx_await;
	logic tx_request;

	// Sender status, passed straight to the user
	logic tx_done;
	logic tx_timeout;

	ps2_line_sampler sampler_inst (
		.clk        (clk),
		.reset      (reset),
		.ps2_clk_in (ps2_clk_in),
		.ps2_dat_in (ps2_dat_in),
		.line_data  (line_data),
		.clk_rise   (clk_rise),
		.clk_fall   (clk_fall)
	);

	ps2_link_arbiter arbiter_inst (
		.clk              (clk),
		.reset            (reset),
		.send_command     (send_command),
		.line_data        (line_data),
		.clk_rise         (clk_rise),
		.received_data_en (received_data_en),
		.tx_done          (tx_done),
		.tx_timeout       (tx_timeout),
		.rx_start         (rx_start),
		.rx_await         (rx_await),
		.tx_request       (tx_request)
	);

	ps2_rx_deserializer rx_inst (
		.clk              (clk),
		.reset            (reset),
		.rx_start         (rx_start),
		.rx_await         (rx_await),
		.line_data        (line_data),
		.clk_rise         (clk_rise),
		.received_data    (received_data),
		.received_data_en (received_data_en)
	);

	ps2_tx_serializer #(
		.REQUEST_CYCLES       (REQUEST_CYCLES),
		.START_TIMEOUT_CYCLES (START_TIMEOUT_CYCLES),
		.BIT_TIMEOUT_CYCLES   (BIT_TIMEOUT_CYCLES)
	) tx_inst (
		.clk          (clk),
		.reset        (reset),
		.tx_request   (tx_request),
		.clk_rise     (clk_rise),
		.clk_fall     (clk_fall),
		.command      (command),
		.ps2_clk_pull (ps2_clk_pull),
		.ps2_dat_pull (ps2_dat_pull),
		.tx_done      (tx_done),
		.tx_timeout   (tx_timeout)
	);

	assign command_was_sent = tx_done;
	assign error_timed_out  = tx_timeout;

endmodule

//--- logic/ps2_line_sampler.sv
////////////////////////////////////////////////////////////////////////////
// Line inputs are asynchronous; two flops each, edges seen 2 cycles late
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_line_sampler (
	input  logic clk,
	input  logic reset,
	input  logic ps2_clk_in,
	input  logic ps2_dat_in,
	output logic line_data,
	output logic clk_rise,
	output logic clk_fall
);

	// Synchronizer stages and previous sampled clock
	logic clk_meta;
	logic clk_sync;
	logic clk_last;
	logic dat_meta;
	logic dat_sync;

	always_ff @(posedge clk)
	begin
		// Idle bus is high on both lines
		if (reset)
		begin
			clk_meta <= 1'b1;
			clk_sync <= 1'b1;
			clk_last <= 1'b1;
			dat_meta <= 1'b1;
			dat_sync <= 1'b1;
		end
		else
		begin
			clk_meta <= ps2_clk_in;
			clk_sync <= clk_meta;
			clk_last <= clk_sync;
			dat_meta <= ps2_dat_in;
			dat_sync <= dat_meta;
		end
	end

	// Single-cycle edge pulses
	assign clk_rise  = clk_sync & ~clk_last;
	assign clk_fall  = ~clk_sync & clk_last;
	assign line_data = dat_sync;

endmodule

//--- logic/ps2_link_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Commands wait for an idle line; a device start bit always wins in idle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_link_arbiter
	import ps2_timing_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic send_command,
	input  logic line_data,
	input  logic clk_rise,
	input  logic received_data_en,
	input  logic tx_done,
	input  logic tx_timeout,
	output logic rx_start,
	output logic rx_await,
	output logic tx_request
);

	localparam int IDLE_W = $clog2(IDLE_WAIT_CYCLES + 1);
	localparam logic [IDLE_W-1:0] IDLE_FULL = IDLE_W'(IDLE_WAIT_CYCLES);

	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_DATA_IN = 3'd1;
	localparam logic [2:0] ST_CMD_OUT = 3'd2;
	localparam logic [2:0] ST_END_XFR = 3'd3;
	localparam logic [2:0] ST_END_DLY = 3'd4;

	logic [2:0]        state;
	logic [2:0]        state_next;
	logic [IDLE_W-1:0] idle_cnt;
	logic              start_bit;

	// Low data at a clock rise marks a device start bit
	assign start_bit = !line_data && clk_rise;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (start_bit)
					state_next = ST_DATA_IN;
				else if ((idle_cnt == IDLE_FULL) && send_command)
					state_next = ST_CMD_OUT;
			ST_DATA_IN:
				if (received_data_en)
					state_next = ST_IDLE;
			ST_CMD_OUT:
				if (tx_done || tx_timeout)
					state_next = ST_END_XFR;
			// Listen for the reply while the user holds send_command
			ST_END_XFR:
				if (!send_command)
					state_next = ST_IDLE;
				else if (start_bit)
					state_next = ST_END_DLY;
			ST_END_DLY:
				if (received_data_en)
					state_next = send_command ? ST_END_XFR : ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// Saturating count of idle cycles
	always_ff @(posedge clk)
	begin
		if (reset)
			idle_cnt <= '0;
		else if (state != ST_IDLE)
			idle_cnt <= '0;
		else if (idle_cnt != IDLE_FULL)
			idle_cnt <= idle_cnt + 1'b1;
	end

	assign rx_start = (state == ST_DATA_IN);
	assign rx_await = (state == ST_END_XFR);

	// Held through the end states so sender status stays up
	assign tx_request = send_command &&
		((state == ST_CMD_OUT) || (state == ST_END_XFR) || (state == ST_END_DLY));

endmodule

//--- logic/ps2_rx_deserializer.sv
////////////////////////////////////////////////////////////////////////////
// Samples data on clock rises; parity and stop bit are not checked
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_rx_deserializer
	import ps2_frame_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      rx_start,
	input  logic      rx_await,
	input  logic      line_data,
	input  logic      clk_rise,
	output ps2_byte_t received_data,
	output logic      received_data_en
);

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_WAIT   = 3'd1;
	localparam logic [2:0] ST_DATA   = 3'd2;
	localparam logic [2:0] ST_PARITY = 3'd3;
	localparam logic [2:0] ST_STOP   = 3'd4;

	logic [2:0] state;
	logic [2:0] state_next;
	bit_index_t data_count;
	ps2_byte_t  shift_reg;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			// Hold off while the last strobe is still out
			ST_IDLE:
				if (rx_await && !received_data_en)
					state_next = ST_WAIT;
				else if (rx_start && !received_data_en)
					state_next = ST_DATA;
			// Start bit is a low data line at a clock rise
			ST_WAIT:
				if (!line_data && clk_rise)
					state_next = ST_DATA;
				else if (!rx_await)
					state_next = ST_IDLE;
			ST_DATA:
				if (clk_rise && (data_count == bit_index_t'(DATA_BITS - 1)))
					state_next = ST_PARITY;
			// Parity passes through unchecked
			ST_PARITY:
				if (clk_rise)
					state_next = ST_STOP;
			ST_STOP:
				if (clk_rise)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// Bit count within the data phase
	always_ff @(posedge clk)
	begin
		if (reset)
			data_count <= '0;
		else if (state != ST_DATA)
			data_count <= '0;
		else if (clk_rise)
			data_count <= data_count + 1'b1;
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if ((state == ST_DATA) && clk_rise)
			shift_reg <= {line_data, shift_reg[DATA_BITS-1:1]};
		if ((state == ST_STOP) && clk_rise)
			received_data <= shift_reg;
	end

	// Strobe one cycle after the stop bit rise
	always_ff @(posedge clk)
	begin
		if (reset)
			received_data_en <= 1'b0;
		else
			received_data_en <= (state == ST_STOP) && clk_rise;
	end

endmodule

//--- logic/ps2_timing_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Default cycle counts, valid only for a 50 MHz system clock
////////////////////////////////////////////////////////////////////////////
package ps2_timing_pkg;

	// Clock line held low before a command, 101 us
	localparam int DEF_REQUEST_CYCLES = 5050;

	// Device must clock within 15 ms of the request
	localparam int DEF_START_TIMEOUT_CYCLES = 750000;

	// Rest of the frame plus acknowledge, 2 ms
	localparam int DEF_BIT_TIMEOUT_CYCLES = 100000;

	// Idle line cycles before a command may start
	// Fixed, independent of clock rate tuning
	localparam int IDLE_WAIT_CYCLES = 255;

endpackage

//--- logic/ps2_tx_serializer.sv
////////////////////////////////////////////////////////////////////////////
// Timeouts in system cycles; tx_request must stay high until done or error
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_tx_serializer
	import ps2_frame_pkg::*;
	import ps2_timing_pkg::*;
#(
	parameter int REQUEST_CYCLES       = DEF_REQUEST_CYCLES,
	parameter int START_TIMEOUT_CYCLES = DEF_START_TIMEOUT_CYCLES,
	parameter int BIT_TIMEOUT_CYCLES   = DEF_BIT_TIMEOUT_CYCLES
)
(
	input  logic      clk,
	input  logic      reset,
	input  logic      tx_request,
	input  logic      clk_rise,
	input  logic      clk_fall,
	input  ps2_byte_t command,
	output logic      ps2_clk_pull,
	output logic      ps2_dat_pull,
	output logic      tx_done,
	output logic      tx_timeout
);

	localparam int REQ_W   = $clog2(REQUEST_CYCLES + 1);
	localparam int START_W = $clog2(START_TIMEOUT_CYCLES + 1);
	localparam int BIT_W   = $clog2(BIT_TIMEOUT_CYCLES + 1);

	// Request ends after exactly REQUEST_CYCLES cycles
	localparam logic [REQ_W-1:0]   REQ_LAST    = REQ_W'(REQUEST_CYCLES - 1);
	localparam logic [REQ_W-1:0]   REQ_HALF    = REQ_W'(REQUEST_CYCLES / 2);
	localparam logic [START_W-1:0] START_LIMIT = START_W'(START_TIMEOUT_CYCLES);
	localparam logic [BIT_W-1:0]   BIT_LIMIT   = BIT_W'(BIT_TIMEOUT_CYCLES);

	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_REQUEST = 3'd1;
	localparam logic [2:0] ST_WAITCLK = 3'd2;
	localparam logic [2:0] ST_SHIFT   = 3'd3;
	localparam logic [2:0] ST_STOP    = 3'd4;
	localparam logic [2:0] ST_ACK     = 3'd5;
	localparam logic [2:0] ST_DONE    = 3'd6;
	localparam logic [2:0] ST_ERROR   = 3'd7;

	logic [2:0]         state;
	logic [2:0]         state_next;
	logic [DATA_BITS:0] frame_bits;
	bit_index_t         bit_cnt;
	logic [REQ_W-1:0]   req_cnt;
	logic [START_W-1:0] start_cnt;
	logic [BIT_W-1:0]   xfer_cnt;
	logic               in_frame;

	// Shift, stop and ack share one timeout
	assign in_frame = (state == ST_SHIFT) || (state == ST_STOP) || (state == ST_ACK);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (tx_request)
					state_next = ST_REQUEST;
			ST_REQUEST:
				if (req_cnt == REQ_LAST)
					state_next = ST_WAITCLK;
			// First device fall clocks out the start bit
			ST_WAITCLK:
				if (clk_fall)
					state_next = ST_SHIFT;
				else if (start_cnt == START_LIMIT)
					state_next = ST_ERROR;
			// Parity is the ninth bit, index DATA_BITS
			ST_SHIFT:
				if (clk_fall && (bit_cnt == bit_index_t'(DATA_BITS)))
					state_next = ST_STOP;
				else if (xfer_cnt == BIT_LIMIT)
					state_next = ST_ERROR;
			ST_STOP:
				if (clk_fall)
					state_next = ST_ACK;
				else if (xfer_cnt == BIT_LIMIT)
					state_next = ST_ERROR;
			// Device acknowledge ends on a clock rise
			ST_ACK:
				if (clk_rise)
					state_next = ST_DONE;
				else if (xfer_cnt == BIT_LIMIT)
					state_next = ST_ERROR;
			ST_DONE, ST_ERROR:
				if (!tx_request)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// Command with parity, frozen once the request starts
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE)
			frame_bits <= {ps2_odd_parity(command), command};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bit_cnt   <= '0;
			req_cnt   <= '0;
			start_cnt <= '0;
			xfer_cnt  <= '0;
		end
		else
		begin
			if (state != ST_SHIFT)
				bit_cnt <= '0;
			else if (clk_fall)
				bit_cnt <= bit_cnt + 1'b1;
			if (state != ST_REQUEST)
				req_cnt <= '0;
			else
				req_cnt <= req_cnt + 1'b1;
			// Timeout counters saturate at their limit
			if (state != ST_WAITCLK)
				start_cnt <= '0;
			else if (start_cnt != START_LIMIT)
				start_cnt <= start_cnt + 1'b1;
			if (!in_frame)
				xfer_cnt <= '0;
			else if (xfer_cnt != BIT_LIMIT)
				xfer_cnt <= xfer_cnt + 1'b1;
		end
	end

	assign ps2_clk_pull = (state == ST_REQUEST);

	// Data low from mid request through start bit, then the frame bits
	always_comb
	begin
		case (state)
			ST_REQUEST: ps2_dat_pull = (req_cnt >= REQ_HALF);
			ST_WAITCLK: ps2_dat_pull = 1'b1;
			ST_SHIFT:   ps2_dat_pull = ~frame_bits[bit_cnt];
			default:    ps2_dat_pull = 1'b0;
		endcase
	end

	assign tx_done    = (state == ST_DONE);
	assign tx_timeout = (state == ST_ERROR);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PS/2 host testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module ps2_host_tb -f src.f -o ps2_host_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/ps2_host_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation run returned an error status"
	exit 1
fi

cat "$LOG"
if grep -qx "Simulation PASSED" "$LOG"; then
	exit 0
fi
exit 1

//--- src.f
logic/ps2_frame_pkg.sv
logic/ps2_timing_pkg.sv
logic/ps2_line_sampler.sv
logic/ps2_rx_deserializer.sv
logic/ps2_tx_serializer.sv
logic/ps2_link_arbiter.sv
logic/ps2_host.sv
dv/ps2_host_chk.sv
dv/ps2_device_model.sv
dv/ps2_scoreboard.sv
dv/ps2_host_tb.sv
